/* common/emesh_pkg.sv */
`default_nettype none

package emesh_pkg;

   //##########################################################################
   // Sizes
   //##########################################################################
   localparam int PACKET_W   = 104;                // Full eMesh transaction
   localparam int MEM_WORDS  = 256;                // 1 KB endpoint memory
   localparam int FIFO_DEPTH = 16;                 // Input buffer entries
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // Pointer width

   //##########################################################################
   // Field types
   //##########################################################################
   typedef logic [31:0]        addr_t;
   typedef logic [31:0]        data_t;
   typedef logic [11:0]        chipid_t;           // dstaddr[31:20]
   typedef logic [3:0]         ctrlmode_t;
   typedef logic [1:0]         datamode_t;         // 0 byte, 1 half, 2/3 word
   typedef logic [7:0]         mem_index_t;        // dstaddr[9:2]
   typedef logic [1:0]         byte_off_t;         // dstaddr[1:0]
   typedef logic [FIFO_AW-1:0] fifo_ptr_t;
   typedef logic [FIFO_AW:0]   fifo_cnt_t;         // One extra bit for full

   localparam chipid_t   LINK_ID = 12'h810;        // Own ID, never a memory hit
   localparam datamode_t DM_BYTE = 2'd0;
   localparam datamode_t DM_HALF = 2'd1;

   //##########################################################################
   // Transaction and internal request formats
   //##########################################################################
   typedef struct packed {
      addr_t     srcaddr;                          // [103:72]
      data_t     data;                             // [71:40]
      addr_t     dstaddr;                          // [39:8]
      ctrlmode_t ctrlmode;                         // [7:4]
      datamode_t datamode;                         // [3:2]
      logic      write;                            // [1]
      logic      rsvd;                             // [0]
   } emesh_packet_t;

   // Controller to memory array
   typedef struct packed {
      logic       valid;
      logic       write;
      mem_index_t index;
      byte_off_t  offset;
      datamode_t  datamode;
      data_t      wdata;
   } mem_req_t;

   // Read context carried next to the array output
   typedef struct packed {
      addr_t      srcaddr;                         // Requester, becomes dstaddr
      addr_t      dstaddr;                         // Becomes response srcaddr
      ctrlmode_t  ctrlmode;
      datamode_t  datamode;
      byte_off_t  offset;                          // Lane select for alignment
   } resp_info_t;

   typedef enum logic {
      RUN,                                         // Pipeline moving
      STALL                                        // Response held by resp_wait
   } ctrl_state_t;

endpackage

`default_nettype wire

/* emem/emem_array.sv */
`default_nettype none

module emem_array import emesh_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  mem_req_t mem_req,
   input  logic     hold,
   output data_t    rd_word,
   output logic     rd_valid
);

   data_t      mem [MEM_WORDS];        // Word storage
   logic [3:0] lane_en;                // Byte enables
   data_t      lane_data;              // Write data replicated over lanes
   logic       wr_en;
   logic       rd_en;
   data_t      rd_word_q;
   logic       rd_valid_q;

   assign wr_en = mem_req.valid & mem_req.write;
   assign rd_en = mem_req.valid & ~mem_req.write;

   //##########################################################################
   // Byte-lane decode
   //##########################################################################
   always_comb begin
      case (mem_req.datamode)
         DM_BYTE: begin
            lane_en   = 4'b0001 << mem_req.offset;
            lane_data = {4{mem_req.wdata[7:0]}};
         end
         DM_HALF: begin
            lane_en   = mem_req.offset[1] ? 4'b1100 : 4'b0011;  // Offset bit 0 ignored
            lane_data = {2{mem_req.wdata[15:0]}};
         end
         default: begin                                         // Word, double as word
            lane_en   = 4'b1111;
            lane_data = mem_req.wdata;
         end
      endcase
   end

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < 4; i++) begin
            if (lane_en[i]) begin
               mem[mem_req.index][8*i +: 8] <= lane_data[8*i +: 8];
            end
         end
      end
   end

   //##########################################################################
   // Registered read port, frozen by hold
   //##########################################################################
   always_ff @(posedge clk) begin
      if (rd_en && !hold) begin
         rd_word_q <= mem[mem_req.index];                       // Whole word, aligned later
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else if (!hold) begin
         rd_valid_q <= rd_en;
      end
   end

   assign rd_word  = rd_word_q;
   assign rd_valid = rd_valid_q;

endmodule

`default_nettype wire

/* emem/emem_ctrl.sv */
`default_nettype none

module emem_ctrl import emesh_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   // FIFO head
   input  logic          fifo_access,
   input  emesh_packet_t fifo_packet,
   output logic          fifo_pop,
   // Array and response stage
   output mem_req_t      mem_req,
   output resp_info_t    rsp_info,
   output logic          hold,
   // Response handshake
   input  logic          resp_access,
   input  logic          resp_wait
);

   ctrl_state_t state;
   ctrl_state_t state_next;
   chipid_t     head_chipid;
   logic        is_local;          // Addressed to this link, discard
   logic        is_write;
   logic        is_read;
   logic        wr_pop;
   logic        rd_pop;
   resp_info_t  info_q;            // Context of read now in array register

   //##########################################################################
   // Head decode and chip-ID filter
   //##########################################################################
   assign head_chipid = fifo_packet.dstaddr[31:20];
   assign is_local    = fifo_access & (head_chipid == LINK_ID);
   assign is_write    = fifo_access & ~is_local & fifo_packet.write;
   assign is_read     = fifo_access & ~is_local & ~fifo_packet.write;

   //##########################################################################
   // Back-pressure FSM
   //##########################################################################
   always_comb begin
      case (state)
         STALL:   hold = resp_wait;                 // Held response is still valid
         default: hold = resp_access & resp_wait;
      endcase
   end

   always_comb begin
      state_next = state;
      case (state)
         RUN: begin
            if (hold) begin
               state_next = STALL;
            end
         end
         STALL: begin
            if (!hold) begin
               state_next = RUN;                    // Response taken
            end
         end
         default: state_next = RUN;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= RUN;
      end else begin
         state <= state_next;
      end
   end

   //##########################################################################
   // Pop and memory request
   //##########################################################################
   assign wr_pop   = is_write;                      // Writes never touch read pipe
   assign rd_pop   = is_read & ~hold;               // Read at head blocks the rest
   assign fifo_pop = is_local | wr_pop | rd_pop;

   always_comb begin
      mem_req.valid    = wr_pop | rd_pop;
      mem_req.write    = wr_pop;
      mem_req.index    = fifo_packet.dstaddr[9:2];  // Word index
      mem_req.offset   = fifo_packet.dstaddr[1:0];
      mem_req.datamode = fifo_packet.datamode;
      mem_req.wdata    = fifo_packet.data;
   end

   // Read context, aligned with array read register
   always_ff @(posedge clk) begin
      if (rd_pop) begin
         info_q.srcaddr  <= fifo_packet.srcaddr;
         info_q.dstaddr  <= fifo_packet.dstaddr;
         info_q.ctrlmode <= fifo_packet.ctrlmode;
         info_q.datamode <= fifo_packet.datamode;
         info_q.offset   <= fifo_packet.dstaddr[1:0];
      end
   end

   assign rsp_info = info_q;

endmodule

`default_nettype wire

/* emem/emem_resp.sv */
`default_nettype none

module emem_resp import emesh_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  resp_info_t    rsp_info,
   input  data_t         rd_word,
   input  logic          rd_valid,
   input  logic          hold,
   output logic          resp_access,
   output emesh_packet_t resp_packet
);

   data_t         aligned;        // Addressed lanes moved to bit 0
   emesh_packet_t resp_d;
   emesh_packet_t resp_q;
   logic          access_q;

   // Read data alignment, zero extended
   always_comb begin
      case (rsp_info.datamode)
         DM_BYTE: aligned = {24'd0, rd_word[8*rsp_info.offset +: 8]};
         DM_HALF: aligned = {16'd0, rd_word[16*rsp_info.offset[1] +: 16]};
         default: aligned = rd_word;
      endcase
   end

   //##########################################################################
   // Read-response packet
   //##########################################################################
   always_comb begin
      resp_d.srcaddr  = rsp_info.dstaddr;     // Address that was read
      resp_d.data     = aligned;
      resp_d.dstaddr  = rsp_info.srcaddr;     // Back to requester
      resp_d.ctrlmode = rsp_info.ctrlmode;
      resp_d.datamode = rsp_info.datamode;
      resp_d.write    = 1'b1;                 // Responses travel as writes
      resp_d.rsvd     = 1'b0;
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         resp_q <= resp_d;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         access_q <= 1'b0;
      end else if (!hold) begin
         access_q <= rd_valid;                // Kept high while resp_wait stalls
      end
   end

   assign resp_access = access_q;
   assign resp_packet = resp_q;

endmodule

`default_nettype wire

/* hw/emesh_mem_system.sv */
`default_nettype none

module emesh_mem_system import emesh_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   // Incoming transactions
   input  logic          ext_access,
   input  emesh_packet_t ext_packet,
   output logic          ext_wait,
   // Read responses
   output logic          resp_access,
   output emesh_packet_t resp_packet,
   input  logic          resp_wait
);

   logic          fifo_access;      // Head valid
   emesh_packet_t fifo_packet;      // Head entry
   logic          fifo_pop;
   mem_req_t      mem_req;
   resp_info_t    rsp_info;
   logic          hold;             // Freeze read pipeline
   data_t         rd_word;
   logic          rd_valid;

   //##########################################################################
   // Input buffer
   //##########################################################################
   packet_fifo fifo_i (
      .clk         (clk),
      .reset       (reset),
      .push        (ext_access),    // Dropped by FIFO while full
      .push_packet (ext_packet),
      .full        (ext_wait),
      .pop         (fifo_pop),
      .head_valid  (fifo_access),
      .head_packet (fifo_packet)
   );

   //##########################################################################
   // Memory endpoint
   //##########################################################################
   emem_ctrl ctrl_i (
      .clk         (clk),
      .reset       (reset),
      .fifo_access (fifo_access),
      .fifo_packet (fifo_packet),
      .fifo_pop    (fifo_pop),
      .mem_req     (mem_req),
      .rsp_info    (rsp_info),
      .hold        (hold),
      .resp_access (resp_access),
      .resp_wait   (resp_wait)
   );

   emem_array array_i (
      .clk      (clk),
      .reset    (reset),
      .mem_req  (mem_req),
      .hold     (hold),
      .rd_word  (rd_word),
      .rd_valid (rd_valid)
   );

   emem_resp resp_i (
      .clk         (clk),
      .reset       (reset),
      .rsp_info    (rsp_info),
      .rd_word     (rd_word),
      .rd_valid    (rd_valid),
      .hold        (hold),
      .resp_access (resp_access),
      .resp_packet (resp_packet)
   );

endmodule

`default_nettype wire

/* hw/packet_fifo.sv */
`default_nettype none

module packet_fifo import emesh_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          push,
   input  emesh_packet_t push_packet,
   output logic          full,
   input  logic          pop,
   output logic          head_valid,
   output emesh_packet_t head_packet
);

   logic [PACKET_W-1:0] buffer [FIFO_DEPTH];   // Packet storage
   fifo_ptr_t           wr_ptr;
   fifo_ptr_t           rd_ptr;
   fifo_cnt_t           count;                 // Occupancy
   logic                do_push;
   logic                do_pop;

   assign full       = (count == fifo_cnt_t'(FIFO_DEPTH));
   assign head_valid = (count != '0);
   assign head_packet = buffer[rd_ptr];        // Head read straight from storage

   assign do_push = push & ~full;              // Sender holds packet while full
   assign do_pop  = pop & head_valid;          // Pop on empty ignored

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         buffer[wr_ptr] <= push_packet;
      end
   end

   //##########################################################################
   // Pointers and occupancy
   //##########################################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;           // Wraps at depth, power of 2
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_emesh_mem.sv */
`default_nettype none

module tb_emesh_mem import emesh_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD    = 20;         // 40 ns clock
   localparam int DRIVE_DLY      = 5;          // Input skew after rising edge
   localparam int RESET_CYCLES   = 4;
   localparam int RANDOM_PACKETS = 200;
   localparam int BURST_READS    = 24;         // More than FIFO plus pipeline
   localparam int DRAIN_CYCLES   = 200;        // Final drain window
   localparam int MAX_CYCLES     = 4000;       // About 1000 cycles of traffic, wide margin

   logic          clk;
   logic          reset;
   logic          ext_access;
   emesh_packet_t ext_packet;
   logic          ext_wait;
   logic          resp_access;
   emesh_packet_t resp_packet;
   logic          resp_wait;

   integer        seed = 98357;
   data_t         ref_mem [MEM_WORDS];         // Reference memory
   emesh_packet_t exp_q [$];                   // Responses still owed, in order
   emesh_packet_t exp_head;                    // Response due at next edge
   logic          exp_valid;
   emesh_packet_t pkt_now;                     // Response seen this cycle
   emesh_packet_t pkt_prev;
   logic [1:0]    wait_mode;                   // 0 never, 1 random, 2 always
   logic          full_seen;
   int            cycle_count = 0;

   emesh_mem_system dut_i (
      .clk         (clk),
      .reset       (reset),
      .ext_access  (ext_access),
      .ext_packet  (ext_packet),
      .ext_wait    (ext_wait),
      .resp_access (resp_access),
      .resp_packet (resp_packet),
      .resp_wait   (resp_wait)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   //##########################################################################
   // Reference model
   //##########################################################################
   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   function automatic data_t merge_write(data_t old, data_t wdata, datamode_t mode,
                                         byte_off_t off);
      data_t mask;
      case (mode)
         2'd0:    mask = 32'h0000_00ff << (8 * off);      // One lane
         2'd1:    mask = 32'h0000_ffff << (16 * off[1]);  // Lower or upper half
         default: mask = 32'hffff_ffff;
      endcase
      return (old & ~mask) | ((wdata << (8 * off)) & mask & {32{mode == 2'd0}})
             | ((wdata << (16 * off[1])) & mask & {32{mode == 2'd1}})
             | (wdata & {32{mode[1]}});
   endfunction

   function automatic data_t lane_value(data_t word, datamode_t mode, byte_off_t off);
      case (mode)
         2'd0:    return (word >> (8 * off)) & 32'h0000_00ff;
         2'd1:    return (word >> (16 * off[1])) & 32'h0000_ffff;
         default: return word;
      endcase
   endfunction

   function automatic void apply_to_model(emesh_packet_t pkt);
      mem_index_t    idx;
      byte_off_t     off;
      emesh_packet_t rsp;
      idx = pkt.dstaddr[9:2];
      off = pkt.dstaddr[1:0];
      if (pkt.dstaddr[31:20] != LINK_ID) begin       // Own ID is dropped
         if (pkt.write) begin
            ref_mem[idx] = merge_write(ref_mem[idx], pkt.data, pkt.datamode, off);
         end else begin
            rsp.srcaddr  = pkt.dstaddr;
            rsp.data     = lane_value(ref_mem[idx], pkt.datamode, off);
            rsp.dstaddr  = pkt.srcaddr;
            rsp.ctrlmode = pkt.ctrlmode;
            rsp.datamode = pkt.datamode;
            rsp.write    = 1'b1;
            rsp.rsvd     = 1'b0;
            exp_q.push_back(rsp);
         end
      end
   endfunction

   // Everything is stable at the falling edge
   always @(negedge clk) begin
      pkt_prev = pkt_now;
      pkt_now  = resp_packet;
      if (!reset) begin
         if (resp_access && !resp_wait) begin        // Taken at next edge
            exp_valid = (exp_q.size() > 0);
            if (exp_valid) begin
               exp_head = exp_q.pop_front();
            end
         end
         if (ext_access && !ext_wait) begin          // Pushed at next edge
            apply_to_model(ext_packet);
         end
      end
   end

   //##########################################################################
   // Checks
   //##########################################################################
   reset_quiet: assert property (@(posedge clk) reset |-> (!ext_wait && !resp_access))
      else stop_on_error($sformatf("CHECK FAILED ext_wait %h resp_access %h in reset",
                                   $sampled(ext_wait), $sampled(resp_access)));

   out_of_reset: assert property (@(posedge clk) $fell(reset) |-> (!ext_wait && !resp_access))
      else stop_on_error($sformatf("CHECK FAILED ext_wait %h resp_access %h after reset",
                                   $sampled(ext_wait), $sampled(resp_access)));

   resp_expected: assert property (@(posedge clk) disable iff (reset)
                                   (resp_access && !resp_wait) |-> exp_valid)
      else stop_on_error("A response arrived with no read outstanding");

   resp_match: assert property (@(posedge clk) disable iff (reset)
                                (resp_access && !resp_wait && exp_valid) |->
                                (resp_packet == exp_head))
      else stop_on_error($sformatf("CHECK FAILED resp_packet got %h expected %h",
                                   $sampled(resp_packet), exp_head));

   held_access: assert property (@(posedge clk) disable iff (reset)
                                 (resp_access && resp_wait) |=> resp_access)
      else stop_on_error("resp_access dropped while resp_wait was high");

   held_packet: assert property (@(posedge clk) disable iff (reset)
                                 (resp_access && resp_wait) |=> $stable(resp_packet))
      else stop_on_error($sformatf("CHECK FAILED resp_packet was %h now %h under resp_wait",
                                   pkt_prev, pkt_now));

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         stop_on_error($sformatf("Timeout with %0d responses still missing", exp_q.size()));
      end
   end

   //##########################################################################
   // Stimulus
   //##########################################################################
   initial begin
      logic [31:0] draw;
      logic [1:0]  mode;
      resp_wait = 1'b0;
      forever begin
         @(negedge clk);
         draw = rand32();                          // Drawn apart from packet stimulus
         mode = wait_mode;                         // Settled since the last drive
         @(posedge clk);
         #DRIVE_DLY;
         resp_wait = (mode == 2'd2) || (mode == 2'd1 && draw[0]);
      end
   end

   task automatic send_packet(input emesh_packet_t pkt);
      ext_packet = pkt;
      ext_access = 1'b1;
      do begin
         @(negedge clk);
      end while (ext_wait);                       // Hold until there is room
      @(posedge clk);
      #DRIVE_DLY;
      ext_access = 1'b0;
   endtask

   task automatic access(input logic wr, input datamode_t mode, input chipid_t chip,
                         input mem_index_t idx, input byte_off_t off);
      emesh_packet_t pkt;
      logic [31:0]   mid;
      mid          = rand32();
      pkt.srcaddr  = rand32();
      pkt.data     = rand32();
      pkt.dstaddr  = {chip, mid[9:0], idx, off};
      pkt.ctrlmode = mid[13:10];
      pkt.datamode = mode;
      pkt.write    = wr;
      pkt.rsvd     = 1'b0;
      send_packet(pkt);
   endtask

   function automatic chipid_t foreign_chip();
      logic [31:0] draw;
      draw = rand32();
      return (draw[11:0] == LINK_ID) ? ~draw[11:0] : draw[11:0];
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
      end
      #DRIVE_DLY;
   endtask

   initial begin
      logic [31:0] draw;
      mem_index_t  idx;
      emesh_packet_t pkt;
      reset      = 1'b0;
      ext_access = 1'b0;
      ext_packet = '0;
      wait_mode  = 2'd0;
      exp_valid  = 1'b0;
      full_seen  = 1'b0;
      #1;
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;
      idle_cycles(2);

      // Fill every word, pattern from the word address
      for (int n = 0; n < MEM_WORDS; n++) begin
         idx          = mem_index_t'(n);
         pkt          = '0;
         pkt.dstaddr  = {foreign_chip(), 10'h0, idx, 2'b00};
         pkt.data     = {~idx, idx ^ 8'h5a, idx + 8'h3c, idx};
         pkt.datamode = 2'd2;
         pkt.write    = 1'b1;
         send_packet(pkt);
      end

      draw = rand32();                            // Word write and read-back
      idx  = draw[7:0];
      access(1'b1, 2'd2, foreign_chip(), idx, 2'd0);
      access(1'b0, 2'd2, foreign_chip(), idx, 2'd0);
      access(1'b1, 2'd3, foreign_chip(), idx + 8'd1, 2'd0);  // Double acts as word
      access(1'b0, 2'd3, foreign_chip(), idx + 8'd1, 2'd0);
      idle_cycles(6);

      idx = draw[15:8];                           // Lane merges
      access(1'b1, 2'd0, foreign_chip(), idx, 2'd1);
      access(1'b1, 2'd1, foreign_chip(), idx, 2'd2);
      access(1'b0, 2'd2, foreign_chip(), idx, 2'd0);
      for (int b = 0; b < 4; b++) begin
         access(1'b0, 2'd0, foreign_chip(), idx, byte_off_t'(b));
         access(1'b0, 2'd1, foreign_chip(), idx, byte_off_t'(b));
      end
      idle_cycles(6);

      idx = draw[23:16];                          // Own chip ID, no effect
      access(1'b1, 2'd2, LINK_ID, idx, 2'd0);
      access(1'b0, 2'd2, LINK_ID, idx, 2'd0);
      access(1'b0, 2'd2, foreign_chip(), idx, 2'd0);
      idle_cycles(6);

      wait_mode = 2'd1;                           // Random response stalls
      for (int i = 0; i < RANDOM_PACKETS; i++) begin
         draw = rand32();
         access(draw[0], draw[3:2], (draw[6:4] == 3'd0) ? LINK_ID : foreign_chip(),
                draw[15:8], draw[17:16]);
         if (draw[7]) begin
            idle_cycles(1);
         end
      end

      wait_mode = 2'd2;                           // Responses blocked, FIFO fills
      idle_cycles(3);
      fork
         begin
            for (int i = 0; i < BURST_READS; i++) begin
               draw = rand32();
               access(1'b0, draw[1:0], foreign_chip(), draw[15:8], draw[17:16]);
            end
         end
         begin
            repeat (BURST_READS * 4) begin
               @(negedge clk);
               full_seen = full_seen | ext_wait;
            end
            @(posedge clk);
            #DRIVE_DLY;
            wait_mode = 2'd0;                     // Let the pipeline drain
         end
      join
      burst_filled: assert (full_seen)
         else stop_on_error("ext_wait never rose during the blocked read burst");

      for (int c = 0; c < DRAIN_CYCLES && exp_q.size() != 0; c++) begin
         @(posedge clk);
      end
      idle_cycles(8);                             // Room for a stray response
      if (exp_q.size() == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         stop_on_error("Expected responses were still missing at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
common/emesh_pkg.sv
hw/packet_fifo.sv
emem/emem_ctrl.sv
emem/emem_array.sv
emem/emem_resp.sv
hw/emesh_mem_system.sv
testbench/tb_emesh_mem.sv
